/* design/rast_params.svh */
`ifndef RAST_PARAMS_SVH
`define RAST_PARAMS_SVH

`default_nettype none

// Fixed-point coordinate format
`define RAST_SIGFIG 24   // Total bits per signed coordinate
`define RAST_RADIX 10    // Fraction bits, one pixel is 1 << RADIX

// Sample test pipeline
`define RAST_PIPE_DEPTH 3 // Register stages from sample in to result out

// Payload widths
`define RAST_TAG_W 4      // Triangle tag, wraps at 16
`define RAST_COLOR_W 8    // One color channel

`default_nettype wire

`endif

/* design/rast_pkg.sv */
`include "rast_params.svh"
`default_nettype none

package rast_pkg;

    typedef logic [2:0][`RAST_COLOR_W-1:0] color_t; // Three channels, r in [2]

    typedef struct packed {
        logic signed [`RAST_SIGFIG-1:0] x; // Fixed point, RADIX fraction bits
        logic signed [`RAST_SIGFIG-1:0] y;
    } vertex_t;

    typedef struct packed {
        vertex_t v0; // Counter-clockwise order for a visible triangle
        vertex_t v1;
        vertex_t v2;
        color_t  color;
    } triangle_t;

    typedef struct packed {
        logic signed [`RAST_SIGFIG-1:0] x; // Always on the pixel grid
        logic signed [`RAST_SIGFIG-1:0] y;
        logic [`RAST_TAG_W-1:0]         tag; // Tag of the owning triangle
    } sample_t;

    typedef struct packed {
        sample_t samp;
        color_t  color;
        logic    hit; // Strictly inside all three edges
    } result_t;

    typedef enum logic {
        IDLE, // Waiting for a triangle
        SCAN  // Walking the bounding box
    } iter_state_e;

endpackage

`default_nettype wire

/* design/tri_iter.sv */
`timescale 1ns/1ps
`include "rast_params.svh"
`default_nettype none

module tri_iter import rast_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  triangle_t tri_in,     // Triangle from the source
    input  logic      tri_valid,
    output logic      tri_ready,  // Low while a box is scanned
    output sample_t   samp,       // Current grid sample
    output triangle_t samp_tri,   // Triangle owning samp
    output logic      samp_valid
);

    localparam int SF = `RAST_SIGFIG;
    localparam int RX = `RAST_RADIX;

    localparam logic signed [SF-1:0] PIX = {{(SF-RX-1){1'b0}}, 1'b1, {RX{1'b0}}}; // One pixel
    localparam logic signed [SF-1:0] PIX_MASK = {{(SF-RX){1'b1}}, {RX{1'b0}}}; // Integer part

    iter_state_e            state;
    logic [`RAST_TAG_W-1:0] tag_cnt;  // Tag for the next accepted triangle
    logic signed [SF-1:0]   x_min;    // Row restart column
    logic signed [SF-1:0]   x_max;    // Last column of a row
    logic signed [SF-1:0]   y_max;    // Last row of the box
    logic signed [SF-1:0]   bx_min;   // Box of the incoming triangle
    logic signed [SF-1:0]   bx_max;
    logic signed [SF-1:0]   by_min;
    logic signed [SF-1:0]   by_max;
    logic                   accept;   // Transfer on this edge
    logic                   row_end;  // Sample sits on the last column
    logic                   last;     // Final sample of the box

    // Round toward minus infinity onto the pixel grid
    function automatic logic signed [SF-1:0] floor_px(input logic signed [SF-1:0] v);
        return v & PIX_MASK; // Two's complement masking floors
    endfunction

    function automatic logic signed [SF-1:0] min3(
        input logic signed [SF-1:0] a,
        input logic signed [SF-1:0] b,
        input logic signed [SF-1:0] c
    );
        logic signed [SF-1:0] m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic logic signed [SF-1:0] max3(
        input logic signed [SF-1:0] a,
        input logic signed [SF-1:0] b,
        input logic signed [SF-1:0] c
    );
        logic signed [SF-1:0] m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Bounding box straight from the input port
    assign bx_min = floor_px(min3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x));
    assign bx_max = floor_px(max3(tri_in.v0.x, tri_in.v1.x, tri_in.v2.x));
    assign by_min = floor_px(min3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y));
    assign by_max = floor_px(max3(tri_in.v0.y, tri_in.v1.y, tri_in.v2.y));

    assign samp_valid = (state == SCAN);
    assign row_end    = (samp.x == x_max);
    assign last       = samp_valid && row_end && (samp.y == y_max);
    assign tri_ready  = (state == IDLE) || last; // Early ready for back-to-back boxes
    assign accept     = tri_valid && tri_ready;

    // Control FSM and tag counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            tag_cnt <= '0;
        end else begin
            if (accept) begin
                state   <= SCAN;
                tag_cnt <= tag_cnt + 1'b1; // Wraps naturally
            end else if (last) begin
                state   <= IDLE;
            end
        end
    end

    // Box registers and sample walker
    always_ff @(posedge clk) begin
        if (accept) begin
            samp_tri <= tri_in;
            x_min    <= bx_min;
            x_max    <= bx_max;
            y_max    <= by_max;
            samp.x   <= bx_min; // First sample at box corner
            samp.y   <= by_min;
            samp.tag <= tag_cnt;
        end else if (samp_valid && !last) begin
            if (row_end) begin
                samp.x <= x_min; // Next row
                samp.y <= samp.y + PIX;
            end else begin
                samp.x <= samp.x + PIX;
            end
        end
    end

endmodule

`default_nettype wire

/* design/sample_test.sv */
`timescale 1ns/1ps
`include "rast_params.svh"
`default_nettype none

module sample_test import rast_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  sample_t   samp,       // One sample per cycle
    input  triangle_t samp_tri,
    input  logic      samp_valid,
    output result_t   res,        // Three cycles after samp
    output logic      res_valid
);

    localparam int SF = `RAST_SIGFIG;
    localparam int DW = SF + 1;  // Vertex minus sample
    localparam int PW = 2 * DW;  // Cross product
    localparam int EW = PW + 1;  // Edge value

    vertex_t              vtx [3];    // Vertices by index

    // Stage 1
    logic                 s1_valid;
    sample_t              s1_samp;
    color_t               s1_color;
    logic signed [DW-1:0] s1_dx [3];  // v.x - s.x
    logic signed [DW-1:0] s1_dy [3];  // v.y - s.y

    // Stage 2
    logic                 s2_valid;
    sample_t              s2_samp;
    color_t               s2_color;
    logic signed [PW-1:0] s2_pa [3];  // dx[a] * dy[b]
    logic signed [PW-1:0] s2_pb [3];  // dx[b] * dy[a]

    // Stage 3 inputs
    logic signed [EW-1:0] edge_val [3];
    logic                 hit_c;

    // Sign-extended difference, never overflows
    function automatic logic signed [DW-1:0] ext_diff(
        input logic [SF-1:0] a,
        input logic [SF-1:0] b
    );
        return {a[SF-1], a} - {b[SF-1], b};
    endfunction

    assign vtx[0] = samp_tri.v0;
    assign vtx[1] = samp_tri.v1;
    assign vtx[2] = samp_tri.v2;

    // Valid chain, the only reset state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            s1_valid  <= samp_valid;
            s2_valid  <= s1_valid;
            res_valid <= s2_valid;
        end
    end

    // Stage 1, translate vertices to sample origin
    always_ff @(posedge clk) begin
        s1_samp  <= samp;
        s1_color <= samp_tri.color;
        for (int i = 0; i < 3; i++) begin
            s1_dx[i] <= ext_diff(vtx[i].x, samp.x);
            s1_dy[i] <= ext_diff(vtx[i].y, samp.y);
        end
    end

    // Stage 2, cross products of edge (i, i+1)
    always_ff @(posedge clk) begin
        s2_samp  <= s1_samp;
        s2_color <= s1_color;
        for (int i = 0; i < 3; i++) begin
            s2_pa[i] <= s1_dx[i] * s1_dy[(i+1)%3];
            s2_pb[i] <= s1_dx[(i+1)%3] * s1_dy[i];
        end
    end

    // Edge values and strict sign test, on-edge is a miss
    always_comb begin
        hit_c = 1'b1;
        for (int i = 0; i < 3; i++) begin
            edge_val[i] = s2_pa[i] - s2_pb[i];
            hit_c       = hit_c && (edge_val[i] > 0);
        end
    end

    // Stage 3, result register
    always_ff @(posedge clk) begin
        res.samp  <= s2_samp;
        res.color <= s2_color;
        res.hit   <= hit_c;
    end

endmodule

`default_nettype wire

/* design/rast_sample_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rast_sample_top import rast_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  triangle_t tri_in,     // Held until tri_ready
    input  logic      tri_valid,
    output logic      tri_ready,
    output result_t   res,        // Valid-only, no stall
    output logic      res_valid
);

    sample_t   samp;        // Iterator to sample test
    triangle_t samp_tri;
    logic      samp_valid;

    // Bounding box walker
    tri_iter u_iter (
        .clk        (clk),
        .rst_n      (rst_n),
        .tri_in     (tri_in),
        .tri_valid  (tri_valid),
        .tri_ready  (tri_ready),
        .samp       (samp),
        .samp_tri   (samp_tri),
        .samp_valid (samp_valid)
    );

    // Three-stage edge test
    sample_test u_test (
        .clk        (clk),
        .rst_n      (rst_n),
        .samp       (samp),
        .samp_tri   (samp_tri),
        .samp_valid (samp_valid),
        .res        (res),
        .res_valid  (res_valid)
    );

endmodule

`default_nettype wire

/* dv/rast_properties.sv */
`timescale 1ns/1ps
`include "rast_params.svh"
`default_nettype none

module rast_properties import rast_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input triangle_t tri_in,
    input logic      tri_valid,
    input logic      tri_ready,
    input logic      samp_valid,  // Iterator output inside the top
    input logic      res_valid
);

    int unsigned n_fail = 0; // Count of fired assertions

    // Second reset cycle onward, flops are settled
    a_reset_idle: assert property (@(posedge clk) !rst_n ##1 !rst_n |-> tri_ready && !res_valid)
        else begin
            n_fail++;
            $error("tri_ready low or res_valid high while in reset");
        end

    // Source holds the triangle until it transfers
    a_tri_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (tri_valid && !tri_ready) |=> $stable(tri_in) && tri_valid)
        else begin
            n_fail++;
            $error("tri_in or tri_valid changed before the transfer");
        end

    // Fixed latency of the edge pipeline
    a_pipe_lat: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid == $past(samp_valid, `RAST_PIPE_DEPTH))
        else begin
            n_fail++;
            $error("res_valid does not follow samp_valid by the pipe depth");
        end

endmodule

bind rast_sample_top rast_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .tri_in     (tri_in),
    .tri_valid  (tri_valid),
    .tri_ready  (tri_ready),
    .samp_valid (samp_valid),
    .res_valid  (res_valid)
);

`default_nettype wire

/* dv/smpl_sb.sv */
`timescale 1ns/1ps
`include "rast_params.svh"
`default_nettype none

module smpl_sb import rast_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  triangle_t tri_in,
    input  logic      tri_valid,
    input  logic      tri_ready,
    input  result_t   res,
    input  logic      res_valid,
    output logic      err,      // Set on the first mismatch
    output int        pending,  // Triangles whose box is not yet fully seen
    output int        n_acc,    // Accepted triangles
    output int        n_hits
);

    localparam int SF = `RAST_SIGFIG;
    localparam int RX = `RAST_RADIX;

    typedef struct packed {
        triangle_t              t;
        logic [`RAST_TAG_W-1:0] tag;   // Expected tag of this triangle
    } entry_t;

    entry_t                 q[$];      // Oldest triangle at the front
    logic [`RAST_TAG_W-1:0] next_tag;
    logic                   walking;   // ex, ey point into the front box
    logic signed [SF-1:0]   ex;        // Next expected grid point
    logic signed [SF-1:0]   ey;

    // Floor of the smallest coordinate
    function automatic logic signed [SF-1:0] grid_lo(input logic signed [SF-1:0] a, b, c);
        logic signed [SF-1:0] m;
        m = (b < a) ? b : a;
        m = (c < m) ? c : m;
        return (m >>> RX) <<< RX;
    endfunction

    // Floor of the largest coordinate
    function automatic logic signed [SF-1:0] grid_hi(input logic signed [SF-1:0] a, b, c);
        logic signed [SF-1:0] m;
        m = (b > a) ? b : a;
        m = (c > m) ? c : m;
        return (m >>> RX) <<< RX;
    endfunction

    // All three edge values strictly positive
    function automatic logic ref_hit(input triangle_t t, input longint sx, input longint sy);
        longint vx[3];
        longint vy[3];
        longint e;
        logic   hit;
        vx[0] = t.v0.x;
        vy[0] = t.v0.y;
        vx[1] = t.v1.x;
        vy[1] = t.v1.y;
        vx[2] = t.v2.x;
        vy[2] = t.v2.y;
        hit = 1'b1;
        for (int a = 0; a < 3; a++) begin
            e = (vx[a] - sx) * (vy[(a+1)%3] - sy) - (vx[(a+1)%3] - sx) * (vy[a] - sy);
            if (e <= 0)
                hit = 1'b0; // On-edge counts as a miss
        end
        return hit;
    endfunction

    task automatic check_result(input string name, input result_t got, input result_t want);
        if (got !== want) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, want);
            err = 1'b1;
        end
    endtask

    task automatic check_tag(input string name, input logic [`RAST_TAG_W-1:0] got,
                             input logic [`RAST_TAG_W-1:0] want);
        if (got !== want) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, want);
            err = 1'b1;
        end
    endtask

    always @(posedge clk) begin : track
        entry_t               cur;
        result_t              want;
        logic signed [SF-1:0] hx;
        logic signed [SF-1:0] hy;
        if (!rst_n) begin
            q.delete();
            next_tag = '0;
            walking  = 1'b0;
            err      = 1'b0;
            pending  = 0;
            n_acc    = 0;
            n_hits   = 0;
        end else begin
            if (res_valid && q.size() == 0) begin
                $display("A result arrived at %0t with no triangle outstanding", $time);
                err = 1'b1;
            end else if (res_valid) begin
                cur = q[0];
                hx  = grid_hi(cur.t.v0.x, cur.t.v1.x, cur.t.v2.x);
                hy  = grid_hi(cur.t.v0.y, cur.t.v1.y, cur.t.v2.y);
                if (!walking) begin
                    ex      = grid_lo(cur.t.v0.x, cur.t.v1.x, cur.t.v2.x); // Box corner
                    ey      = grid_lo(cur.t.v0.y, cur.t.v1.y, cur.t.v2.y);
                    walking = 1'b1;
                end
                check_tag("res.samp.tag", res.samp.tag, cur.tag);
                want.samp.x   = ex;
                want.samp.y   = ey;
                want.samp.tag = cur.tag;
                want.color    = cur.t.color;
                want.hit      = ref_hit(cur.t, ex, ey);
                check_result("res", res, want);
                n_hits += int'(res.hit);
                if (ex == hx && ey == hy) begin
                    void'(q.pop_front()); // Box exhausted
                    walking = 1'b0;
                end else if (ex == hx) begin
                    ex = grid_lo(cur.t.v0.x, cur.t.v1.x, cur.t.v2.x);
                    ey = ey + (1 << RX);
                end else begin
                    ex = ex + (1 << RX);
                end
            end
            if (tri_valid && tri_ready) begin
                cur.t   = tri_in;
                cur.tag = next_tag;
                q.push_back(cur);
                next_tag = next_tag + 1'b1; // Wraps with the tag width
                n_acc++;
            end
            pending = q.size();
        end
    end

endmodule

`default_nettype wire

/* dv/tb_rast_sample.sv */
`timescale 1ns/1ps
`include "rast_params.svh"
`default_nettype none

module tb_rast_sample import rast_pkg::*; ();

    localparam int SF      = `RAST_SIGFIG;
    localparam int PIX     = 1 << `RAST_RADIX;
    localparam int BOX_MAX = 64;  // Largest box in any test is 8 x 8 samples

    logic      clk;
    logic      rst_n;
    triangle_t tri_in;
    logic      tri_valid;
    logic      tri_ready;
    result_t   res;
    logic      res_valid;
    logic      err;
    int        pending;
    int        n_acc;
    int        n_hits;
    int        n_sent;   // Triangles offered to the DUT
    int        cycles;
    int        limit;    // Grows with every triangle sent

    rast_sample_top u_dut (.*);
    smpl_sb         u_sb  (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Run stopped on the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, want);
            abort_run();
        end
    endtask

    always @(posedge err) abort_run();

    always @(u_dut.u_props.n_fail) begin
        if (u_dut.u_props.n_fail != 0) begin
            $display("A handshake or reset assertion fired at %0t", $time);
            abort_run();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, results never drained", cycles);
            abort_run();
        end
    end

    // Coordinates in raw fixed point
    function automatic triangle_t make_tri(input int x0, y0, x1, y1, x2, y2,
                                           input logic [3*`RAST_COLOR_W-1:0] rgb);
        triangle_t t;
        t.v0.x  = SF'(x0);
        t.v0.y  = SF'(y0);
        t.v1.x  = SF'(x1);
        t.v1.y  = SF'(y1);
        t.v2.x  = SF'(x2);
        t.v2.y  = SF'(y2);
        t.color = rgb;
        return t;
    endfunction

    // Called on a falling edge and leaves tri_valid high
    task automatic send_tri(input triangle_t t);
        tri_in    = t;
        tri_valid = 1'b1;
        limit    += BOX_MAX + 50;
        n_sent++;
        while (!tri_ready) @(negedge clk);
        @(negedge clk); // Transfer on the rising edge just passed
    endtask

    task automatic wait_drained();
        while (pending != 0) @(negedge clk);
    endtask

    task automatic idle_after_reset();
        repeat (5) begin
            check_bit("tri_ready", tri_ready, 1'b1);
            check_bit("res_valid", res_valid, 1'b0);
            @(negedge clk);
        end
    endtask

    task automatic single_triangle(input logic cw);
        int h0;
        h0 = n_hits;
        if (cw)
            send_tri(make_tri(1536, 1280, 2304, 5632, 5888, 1536, 24'h336699)); // v1 and v2 swapped
        else
            send_tri(make_tri(1536, 1280, 5888, 1536, 2304, 5632, 24'h336699));
        tri_valid = 1'b0;
        wait_drained();
        if (cw ? (n_hits != h0) : (n_hits == h0)) begin
            $display("Wrong hit count %0d for the %s triangle", n_hits - h0,
                     cw ? "clockwise" : "counter-clockwise");
            abort_run();
        end
    endtask

    // Eighteen boxes so the tag wraps past 15
    task automatic back_to_back_stream();
        fork
            begin
                for (int i = 0; i < 18; i++) begin
                    send_tri(make_tri(i * 256, 0, 3 * PIX + i * 128, PIX / 2,
                                      PIX, 5 * PIX / 2 + (i % 3) * PIX, 24'(i * 24'h0f0f0f)));
                end
                tri_valid = 1'b0;
            end
            begin
                while (!res_valid) @(negedge clk);
                while (pending != 0) begin
                    check_bit("res_valid", res_valid, 1'b1); // No bubble between boxes
                    @(negedge clk);
                end
            end
        join
    endtask

    task automatic wait_while_busy();
        send_tri(make_tri(0, 0, 6 * PIX, PIX, 2 * PIX, 6 * PIX, 24'hc08040));
        tri_valid = 1'b0;
        repeat (3) @(negedge clk);
        tri_in    = make_tri(PIX, PIX, 3 * PIX, PIX, PIX, 3 * PIX, 24'h20e0a0);
        tri_valid = 1'b1;
        check_bit("tri_ready", tri_ready, 1'b0); // First box still walking
        send_tri(tri_in);
        tri_valid = 1'b0;
        wait_drained();
    endtask

    // Random vertices in an 8 x 8 pixel square with either winding
    task automatic random_triangles();
        int bx;
        int by;
        int c[6];
        for (int n = 0; n < 50; n++) begin
            bx = int'($urandom_range(127)) - 64;
            by = int'($urandom_range(127)) - 64;
            for (int k = 0; k < 6; k++)
                c[k] = int'($urandom_range(8 * PIX - 1));
            send_tri(make_tri(bx * PIX + c[0], by * PIX + c[1], bx * PIX + c[2],
                              by * PIX + c[3], bx * PIX + c[4], by * PIX + c[5],
                              24'($urandom)));
        end
        tri_valid = 1'b0;
        wait_drained();
    endtask

    initial begin
        void'($urandom(32'h2b54_9d39));
        rst_n     = 1'b0;
        tri_valid = 1'b0;
        tri_in    = '0;
        n_sent    = 0;
        cycles    = 0;
        limit     = 100; // Reset and idle checks
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        single_triangle(1'b0);
        single_triangle(1'b1);
        back_to_back_stream();
        wait_while_busy();
        random_triangles();
        if (pending == 0 && n_acc == n_sent) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Unfinished at the end: %0d pending, %0d of %0d accepted",
                     pending, n_acc, n_sent);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* rast_sample.f */
+incdir+design
design/rast_pkg.sv
design/tri_iter.sv
design/sample_test.sv
design/rast_sample_top.sv
dv/rast_properties.sv
dv/smpl_sb.sv
dv/tb_rast_sample.sv

/* Bender.yml */
package:
  name: rast_sample

sources:
  - include_dirs:
      - design
    files:
      - design/rast_pkg.sv
      - design/tri_iter.sv
      - design/sample_test.sv
      - design/rast_sample_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/rast_properties.sv
      - dv/smpl_sb.sv
      - dv/tb_rast_sample.sv
